// File: Bender.yml
package:
  name: hsp_crm

sources:
  - src/hsp_pkg.sv
  - src/hsp_crm_regs.sv
  - src/hsp_pll_cfg_mux.sv
  - src/hsp_lock_monitor.sv
  - src/hsp_crm_top.sv
  - target: test
    files:
      - bench/hsp_crm_tb.sv

// File: all.f
src/hsp_pkg.sv
src/hsp_crm_regs.sv
src/hsp_pll_cfg_mux.sv
src/hsp_lock_monitor.sv
src/hsp_crm_top.sv
bench/hsp_crm_tb.sv

// File: bench/hsp_crm_tb.sv
// Testbench for the HSP CRM PLL control block
// Applies a step table of APB accesses, mode changes and lock events
// and checks the DUT against a small model of the register map

`timescale 1ns/100ps
`default_nettype none

module hsp_crm_tb
    import hsp_pkg::*;
();

    localparam int CLK_PERIOD = 20;

    localparam logic [31:0] CTRL_RST  = 32'h0000_0006;
    localparam logic [31:0] PMS_RST   = {5'd0, PLL_S_RST, 6'd0, PLL_M_RST, 2'd0, PLL_P_RST};
    localparam logic [31:0] LOCK_RST  = {22'd0, 2'd0, 2'd0, 2'd3, 2'd3, 2'd3};
    localparam logic [31:0] PMS_MASK  = 32'h0703_FF3F;
    localparam logic [31:0] LOCK_MASK = 32'h0000_03FF;

    typedef enum logic [2:0] {K_WR, K_RD, K_MODE, K_LOCK, K_WAIT} kind_e;

    typedef struct packed {
        kind_e       kind;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] exp;
        logic        exp_irq;
    } step_t;

    logic       clk;
    logic       rst_n;
    apb_req_t   apb_req;
    apb_rsp_t   apb_rsp;
    pll_mode_e  pll_mode;
    pll_cfg_t   test_pll_cfg;
    pll_pms_t   sr_pll_pms;
    logic       pll_lock;
    logic [4:0] afc_code;
    pll_cfg_t   pll_cfg;
    logic       irq_lock_lost;

    step_t      steps[$];
    int         n_steps;
    int         n_pass;
    int         n_fail;
    int         step_err;
    pll_cfg_t   reg_model;
    pll_mode_e  mode_model;

    hsp_crm_top hsp_crm_top_i (
        .i_clk_peri2hsp  (clk),
        .i_rst_n         (rst_n),
        .i_apb           (apb_req),
        .o_apb           (apb_rsp),
        .i_pll_mode      (pll_mode),
        .i_test_pll_cfg  (test_pll_cfg),
        .i_sr_pll_pms    (sr_pll_pms),
        .i_pll_lock      (pll_lock),
        .i_pll_afc_code  (afc_code),
        .o_pll_cfg       (pll_cfg),
        .o_irq_lock_lost (irq_lock_lost)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    // Bound on the whole run, scaled by the table length
    initial begin
        wait (n_steps > 0);
        repeat (n_steps * 10 + 20) @(posedge clk);
        $display("Watchdog expired before the step table finished");
        $display("TESTS FAILED");
        $finish;
    end

    //======================================================================
    // Compare tasks
    //======================================================================
    task automatic check_apb_rsp(input apb_rsp_t exp, input apb_rsp_t act, input bit with_data);
        if (act.pready !== exp.pready || act.pslverr !== exp.pslverr ||
            (with_data && act.prdata !== exp.prdata)) begin
            $display("** Error o_apb expected 0x%h actual 0x%h", exp, act);
            step_err++;
        end
    endtask

    task automatic check_pll_cfg(input pll_cfg_t exp, input pll_cfg_t act);
        if (act !== exp) begin
            $display("** Error o_pll_cfg expected 0x%h actual 0x%h", exp, act);
            step_err++;
        end
    endtask

    task automatic check_irq(input logic exp, input logic act);
        if (act !== exp) begin
            $display("** Error o_irq_lock_lost expected 0x%h actual 0x%h", exp, act);
            step_err++;
        end
    endtask

    //======================================================================
    // Reference model
    //======================================================================
    task automatic model_write(input logic [31:0] addr, input logic [31:0] data);
        if (addr[31:CRM_WIN_AW] == '0) begin
            case (addr[CRM_WIN_AW-1:0])
                REG_PLL_CTRL: begin
                    reg_model.resetb    = data[0];
                    reg_model.bypass    = data[1];
                    reg_model.lock_en   = data[2];
                    reg_model.fout_mask = data[3];
                end
                REG_PLL_PMS: begin
                    reg_model.pms.p = data[5:0];
                    reg_model.pms.m = data[17:8];
                    reg_model.pms.s = data[26:24];
                end
                REG_PLL_LOCK_CON: begin
                    reg_model.lock_con_in  = data[1:0];
                    reg_model.lock_con_out = data[3:2];
                    reg_model.lock_con_dly = data[5:4];
                    reg_model.lock_con_rev = data[7:6];
                    reg_model.icp          = data[9:8];
                end
                default: begin
                end
            endcase
        end
    endtask

    function automatic pll_cfg_t expected_cfg(input pll_mode_e mode);
        pll_cfg_t c;
        c = reg_model;
        if (mode == MODE_TEST0) begin
            c = test_pll_cfg;
        end else if (mode == MODE_TEST1) begin
            c.resetb       = test_pll_cfg.resetb;
            c.bypass       = 1'b0;
            c.lock_en      = 1'b1;
            c.fout_mask    = 1'b0;
            c.pms          = sr_pll_pms;
            c.lock_con_in  = SAFE_LOCK_CON_IN;
            c.lock_con_out = SAFE_LOCK_CON_OUT;
            c.lock_con_dly = SAFE_LOCK_CON_DLY;
            c.lock_con_rev = SAFE_LOCK_CON_REV;
            c.icp          = SAFE_ICP;
        end
        return c;
    endfunction

    //======================================================================
    // Stimulus
    //======================================================================
    task automatic add_step(input kind_e kind, input logic [31:0] addr, input logic [31:0] data,
                            input logic [31:0] exp, input logic exp_irq);
        step_t s;
        s.kind    = kind;
        s.addr    = addr;
        s.data    = data;
        s.exp     = exp;
        s.exp_irq = exp_irq;
        steps.push_back(s);
    endtask

    task automatic build_table();
        logic [31:0] pms_val;
        logic [31:0] lock_val;
        logic [31:0] afc;
        pms_val  = $urandom;
        lock_val = $urandom;
        afc      = {19'd0, 5'($urandom), 8'd0};
        add_step(K_RD, 32'(REG_PLL_CTRL), 0, CTRL_RST, 0);
        add_step(K_RD, 32'(REG_PLL_PMS), 0, PMS_RST, 0);
        add_step(K_RD, 32'(REG_PLL_LOCK_CON), 0, LOCK_RST, 0);
        add_step(K_WR, 32'(REG_PLL_PMS), pms_val, 0, 0);
        add_step(K_WR, 32'(REG_PLL_LOCK_CON), lock_val, 0, 0);
        add_step(K_WR, 32'(REG_PLL_CTRL), 32'hFFFF_FFFD, 0, 0);
        add_step(K_RD, 32'(REG_PLL_PMS), 0, pms_val & PMS_MASK, 0);
        add_step(K_RD, 32'(REG_PLL_LOCK_CON), 0, lock_val & LOCK_MASK, 0);
        add_step(K_RD, 32'(REG_PLL_CTRL), 0, 32'h0000_000D, 0);
        add_step(K_RD, 32'(REG_HSP_ID), 0, HSP_ID, 0);
        // Outside the window
        add_step(K_WR, 32'h0001_0004, $urandom, 0, 0);
        add_step(K_RD, 32'h8000_0004, 0, 0, 0);
        add_step(K_RD, 32'(REG_PLL_PMS), 0, pms_val & PMS_MASK, 0);
        add_step(K_MODE, 0, 32'(MODE_TEST0), 0, 0);
        add_step(K_MODE, 0, 32'(MODE_TEST1), 0, 0);
        add_step(K_MODE, 0, 32'd3, 0, 0);
        add_step(K_MODE, 0, 32'(MODE_NORMAL), 0, 0);
        // Lock up, lock lost, then W1C
        add_step(K_LOCK, 0, afc | 32'd1, 0, 0);
        add_step(K_WAIT, 0, 32'd3, 0, 0);
        add_step(K_RD, 32'(REG_PLL_STAT), 0, afc | 32'd1, 0);
        add_step(K_LOCK, 0, afc, 0, 0);
        add_step(K_WAIT, 0, 32'd3, 0, 1);
        add_step(K_RD, 32'(REG_PLL_STAT), 0, afc | 32'h0001_0000, 1);
        add_step(K_WR, 32'(REG_PLL_STAT), 32'h0001_0000, 0, 0);
        add_step(K_RD, 32'(REG_PLL_STAT), 0, afc, 0);
    endtask

    // Setup cycle, then the zero wait state access cycle
    task automatic apb_xfer(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
                            output apb_rsp_t rsp);
        @(posedge clk);
        apb_req.psel    <= 1'b1;
        apb_req.penable <= 1'b0;
        apb_req.pwrite  <= wr;
        apb_req.paddr   <= addr;
        apb_req.pwdata  <= wdata;
        @(posedge clk);
        apb_req.penable <= 1'b1;
        @(negedge clk);
        rsp = apb_rsp;
        @(posedge clk);
        apb_req.psel    <= 1'b0;
        apb_req.penable <= 1'b0;
    endtask

    initial begin
        step_t       st;
        apb_rsp_t    rsp;
        apb_rsp_t    exp_rsp;
        logic [63:0] rnd;
        rnd[63:32] = $urandom(35);
        rnd[31:0]  = $urandom;
        rst_n        = 1'b0;
        apb_req      = '0;
        pll_mode     = MODE_NORMAL;
        test_pll_cfg = rnd[$bits(pll_cfg_t)-1:0];
        rnd          = {$urandom, $urandom};
        sr_pll_pms   = rnd[$bits(pll_pms_t)-1:0];
        pll_lock     = 1'b0;
        afc_code     = '0;
        mode_model   = MODE_NORMAL;
        reg_model    = '0;
        reg_model.bypass       = 1'b1;
        reg_model.lock_en      = 1'b1;
        reg_model.pms.p        = PLL_P_RST;
        reg_model.pms.m        = PLL_M_RST;
        reg_model.pms.s        = PLL_S_RST;
        reg_model.lock_con_in  = 2'd3;
        reg_model.lock_con_out = 2'd3;
        reg_model.lock_con_dly = 2'd3;
        build_table();
        n_steps = steps.size();
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        for (int i = 0; i < n_steps; i++) begin
            st       = steps[i];
            step_err = 0;
            case (st.kind)
                K_WR, K_RD: begin
                    apb_xfer(st.kind == K_WR, st.addr, st.data, rsp);
                    exp_rsp.prdata  = st.exp;
                    exp_rsp.pready  = 1'b1;
                    exp_rsp.pslverr = |st.addr[31:CRM_WIN_AW];
                    check_apb_rsp(exp_rsp, rsp, st.kind == K_RD);
                    if (st.kind == K_WR) begin
                        model_write(st.addr, st.data);
                    end
                end
                K_MODE: begin
                    @(posedge clk);
                    pll_mode   <= pll_mode_e'(st.data[1:0]);
                    mode_model  = pll_mode_e'(st.data[1:0]);
                end
                K_LOCK: begin
                    @(posedge clk);
                    pll_lock <= st.data[0];
                    afc_code <= st.data[12:8];
                end
                default: repeat (st.data) @(posedge clk);
            endcase
            @(negedge clk);
            check_pll_cfg(expected_cfg(mode_model), pll_cfg);
            check_irq(st.exp_irq, irq_lock_lost);
            if (step_err == 0) begin
                n_pass++;
                $display("Step %0d %s ok", i, st.kind.name());
            end else begin
                n_fail++;
                $display("Step %0d %s had %0d errors", i, st.kind.name(), step_err);
            end
        end

        $display("Steps passed %0d, failed %0d", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src/hsp_crm_regs.sv
// HSP CRM register file
// Zero wait state APB slave holding the PLL control, divider and
// lock config registers, with lock status, AFC code and ID readback.
// Out of window accesses answer with an error and do nothing

`timescale 1ns/100ps
`default_nettype none

module hsp_crm_regs
    import hsp_pkg::*;
(
    input  wire logic       i_clk_peri2hsp,
    input  wire logic       i_rst_n,
    input  apb_req_t        i_apb,
    output apb_rsp_t        o_apb,
    output pll_cfg_t        o_reg_cfg,
    input  wire logic       i_lock_sync,
    input  wire logic       i_lock_lost,
    output logic            o_lock_lost_clr,
    input  wire logic [4:0] i_pll_afc_code
);

    pll_cfg_t              r_cfg;
    logic [4:0]            afc_q;
    logic                  access;
    logic                  in_window;
    logic                  wr_en;
    logic [CRM_WIN_AW-1:0] offset;
    logic [HSP_APB_DW-1:0] rdata;

    //======================================================================
    // Decode
    //======================================================================
    assign access    = i_apb.psel & i_apb.penable;
    assign in_window = ~|i_apb.paddr[HSP_APB_AW-1:CRM_WIN_AW];
    assign offset    = i_apb.paddr[CRM_WIN_AW-1:0];
    assign wr_en     = access & i_apb.pwrite & in_window;

    // W1C pulse for the sticky lock lost flag
    assign o_lock_lost_clr = wr_en & (offset == REG_PLL_STAT) & i_apb.pwdata[16];

    //======================================================================
    // Config registers
    //======================================================================
    always_ff @(posedge i_clk_peri2hsp) begin
        if (!i_rst_n) begin
            // PLL held in reset and bypassed until software starts it
            r_cfg.resetb       <= 1'b0;
            r_cfg.bypass       <= 1'b1;
            r_cfg.lock_en      <= 1'b1;
            r_cfg.fout_mask    <= 1'b0;
            r_cfg.pms.p        <= PLL_P_RST;
            r_cfg.pms.m        <= PLL_M_RST;
            r_cfg.pms.s        <= PLL_S_RST;
            r_cfg.lock_con_in  <= 2'd3;
            r_cfg.lock_con_out <= 2'd3;
            r_cfg.lock_con_dly <= 2'd3;
            r_cfg.lock_con_rev <= 2'd0;
            r_cfg.icp          <= 2'd0;
        end else if (wr_en) begin
            case (offset)
                REG_PLL_CTRL: begin
                    r_cfg.resetb    <= i_apb.pwdata[0];
                    r_cfg.bypass    <= i_apb.pwdata[1];
                    r_cfg.lock_en   <= i_apb.pwdata[2];
                    r_cfg.fout_mask <= i_apb.pwdata[3];
                end
                REG_PLL_PMS: begin
                    r_cfg.pms.p <= i_apb.pwdata[5:0];
                    r_cfg.pms.m <= i_apb.pwdata[17:8];
                    r_cfg.pms.s <= i_apb.pwdata[26:24];
                end
                REG_PLL_LOCK_CON: begin
                    r_cfg.lock_con_in  <= i_apb.pwdata[1:0];
                    r_cfg.lock_con_out <= i_apb.pwdata[3:2];
                    r_cfg.lock_con_dly <= i_apb.pwdata[5:4];
                    r_cfg.lock_con_rev <= i_apb.pwdata[7:6];
                    r_cfg.icp          <= i_apb.pwdata[9:8];
                end
                default: begin
                end
            endcase
        end
    end

    // AFC code from the PLL macro, one cycle late
    always_ff @(posedge i_clk_peri2hsp) begin
        afc_q <= i_pll_afc_code;
    end

    //======================================================================
    // Read data
    //======================================================================
    always_comb begin
        rdata = '0;
        if (access && in_window) begin
            case (offset)
                REG_PLL_CTRL: begin
                    rdata[0] = r_cfg.resetb;
                    rdata[1] = r_cfg.bypass;
                    rdata[2] = r_cfg.lock_en;
                    rdata[3] = r_cfg.fout_mask;
                end
                REG_PLL_PMS: begin
                    rdata[5:0]   = r_cfg.pms.p;
                    rdata[17:8]  = r_cfg.pms.m;
                    rdata[26:24] = r_cfg.pms.s;
                end
                REG_PLL_LOCK_CON: begin
                    rdata[1:0] = r_cfg.lock_con_in;
                    rdata[3:2] = r_cfg.lock_con_out;
                    rdata[5:4] = r_cfg.lock_con_dly;
                    rdata[7:6] = r_cfg.lock_con_rev;
                    rdata[9:8] = r_cfg.icp;
                end
                REG_PLL_STAT: begin
                    rdata[0]    = i_lock_sync;
                    rdata[12:8] = afc_q;
                    rdata[16]   = i_lock_lost;
                end
                REG_HSP_ID: rdata = HSP_ID;
                default:    rdata = '0;
            endcase
        end
    end

    assign o_apb.prdata  = rdata;
    assign o_apb.pready  = i_apb.psel;
    assign o_apb.pslverr = access & ~in_window;

    assign o_reg_cfg = r_cfg;

endmodule

`default_nettype wire

// File: src/hsp_crm_top.sv
// HSP clock and reset manager, PLL control top
// Joins the APB register file, the PLL test mode mux and the
// lock monitor

`timescale 1ns/100ps
`default_nettype none

module hsp_crm_top
    import hsp_pkg::*;
(
    input  wire logic       i_clk_peri2hsp,
    input  wire logic       i_rst_n,
    input  apb_req_t        i_apb,
    output apb_rsp_t        o_apb,
    input  pll_mode_e       i_pll_mode,
    input  pll_cfg_t        i_test_pll_cfg,
    input  pll_pms_t        i_sr_pll_pms,
    input  wire logic       i_pll_lock,
    input  wire logic [4:0] i_pll_afc_code,
    output pll_cfg_t        o_pll_cfg,
    output logic            o_irq_lock_lost
);

    pll_cfg_t r_cfg;
    logic     lock_lost_clr;
    logic     lock_sync;
    logic     lock_lost;

    hsp_crm_regs u_hsp_crm_regs (
        .i_clk_peri2hsp  (i_clk_peri2hsp),
        .i_rst_n         (i_rst_n),
        .i_apb           (i_apb),
        .o_apb           (o_apb),
        .o_reg_cfg       (r_cfg),
        .i_lock_sync     (lock_sync),
        .i_lock_lost     (lock_lost),
        .o_lock_lost_clr (lock_lost_clr),
        .i_pll_afc_code  (i_pll_afc_code)
    );

    hsp_pll_cfg_mux u_hsp_pll_cfg_mux (
        .i_pll_mode      (i_pll_mode),
        .i_reg_cfg       (r_cfg),
        .i_test_pll_cfg  (i_test_pll_cfg),
        .i_sr_pll_pms    (i_sr_pll_pms),
        .o_pll_cfg       (o_pll_cfg)
    );

    hsp_lock_monitor u_hsp_lock_monitor (
        .i_clk_peri2hsp  (i_clk_peri2hsp),
        .i_rst_n         (i_rst_n),
        .i_pll_lock      (i_pll_lock),
        .i_clr           (lock_lost_clr),
        .o_lock_sync     (lock_sync),
        .o_lock_lost     (lock_lost)
    );

    assign o_irq_lock_lost = lock_lost;

endmodule

`default_nettype wire

// File: src/hsp_lock_monitor.sv
// PLL lock monitor
// Brings the asynchronous lock signal into the bus clock domain and
// keeps a sticky lock lost flag, set on a falling synced lock and
// cleared by software. The flag doubles as the interrupt

`timescale 1ns/100ps
`default_nettype none

module hsp_lock_monitor
    import hsp_pkg::*;
(
    input  wire logic i_clk_peri2hsp,
    input  wire logic i_rst_n,
    input  wire logic i_pll_lock,
    input  wire logic i_clr,
    output logic      o_lock_sync,
    output logic      o_lock_lost
);

    logic [LOCK_SYNC_STAGES-1:0] lock_sync_q;
    logic                        lock_prev_q;
    logic                        lock_fall;
    logic                        lock_lost_q;

    //======================================================================
    // Synchronizer
    //======================================================================
    always_ff @(posedge i_clk_peri2hsp) begin
        if (!i_rst_n) begin
            lock_sync_q <= '0;
            lock_prev_q <= 1'b0;
        end else begin
            lock_sync_q <= {lock_sync_q[LOCK_SYNC_STAGES-2:0], i_pll_lock};
            lock_prev_q <= lock_sync_q[LOCK_SYNC_STAGES-1];
        end
    end

    assign o_lock_sync = lock_sync_q[LOCK_SYNC_STAGES-1];
    assign lock_fall   = lock_prev_q & ~o_lock_sync;

    // Sticky flag, a new loss beats a clear in the same cycle
    always_ff @(posedge i_clk_peri2hsp) begin
        if (!i_rst_n) begin
            lock_lost_q <= 1'b0;
        end else if (lock_fall) begin
            lock_lost_q <= 1'b1;
        end else if (i_clr) begin
            lock_lost_q <= 1'b0;
        end
    end

    assign o_lock_lost = lock_lost_q;

endmodule

`default_nettype wire

// File: src/hsp_pkg.sv
// HSP clock and reset manager package
// Register map, reset values and test mode 1 safe defaults
// for the PLL control block, plus the APB and PLL config types

`default_nettype none

package hsp_pkg;

    //======================================================================
    // Bus widths
    //======================================================================
    localparam int HSP_APB_AW = 32;
    localparam int HSP_APB_DW = 32;
    // Offset bits decoded inside the CRM window
    localparam int CRM_WIN_AW = 12;

    //======================================================================
    // Register offsets
    //======================================================================
    localparam logic [CRM_WIN_AW-1:0] REG_PLL_CTRL     = 12'h000;
    localparam logic [CRM_WIN_AW-1:0] REG_PLL_PMS      = 12'h004;
    localparam logic [CRM_WIN_AW-1:0] REG_PLL_LOCK_CON = 12'h008;
    localparam logic [CRM_WIN_AW-1:0] REG_PLL_STAT     = 12'h00C;
    localparam logic [CRM_WIN_AW-1:0] REG_HSP_ID       = 12'h010;

    // Divider reset values
    localparam logic [5:0] PLL_P_RST = 6'd3;
    localparam logic [9:0] PLL_M_RST = 10'd200;
    localparam logic [2:0] PLL_S_RST = 3'd1;

    localparam logic [HSP_APB_DW-1:0] HSP_ID = 32'h4853_5001;

    // Fixed lock controls used in test mode 1
    localparam logic [1:0] SAFE_LOCK_CON_IN  = 2'd3;
    localparam logic [1:0] SAFE_LOCK_CON_OUT = 2'd3;
    localparam logic [1:0] SAFE_LOCK_CON_DLY = 2'd3;
    localparam logic [1:0] SAFE_LOCK_CON_REV = 2'd0;
    localparam logic [1:0] SAFE_ICP          = 2'd0;

    localparam int LOCK_SYNC_STAGES = 2;

    //======================================================================
    // Types
    //======================================================================
    typedef struct packed {
        logic [5:0] p;
        logic [9:0] m;
        logic [2:0] s;
    } pll_pms_t;

    typedef struct packed {
        logic       resetb;
        logic       bypass;
        logic       lock_en;
        logic       fout_mask;
        pll_pms_t   pms;
        logic [1:0] lock_con_in;
        logic [1:0] lock_con_out;
        logic [1:0] lock_con_dly;
        logic [1:0] lock_con_rev;
        logic [1:0] icp;
    } pll_cfg_t;

    // Code 3 is reserved and treated as normal
    typedef enum logic [1:0] {
        MODE_NORMAL = 2'd0,
        MODE_TEST0  = 2'd1,
        MODE_TEST1  = 2'd2
    } pll_mode_e;

    typedef struct packed {
        logic                  psel;
        logic                  penable;
        logic                  pwrite;
        logic [HSP_APB_AW-1:0] paddr;
        logic [HSP_APB_DW-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [HSP_APB_DW-1:0] prdata;
        logic                  pready;
        logic                  pslverr;
    } apb_rsp_t;

endpackage

`default_nettype wire

// File: src/hsp_pll_cfg_mux.sv
// PLL test mode multiplexer
// Picks the configuration driven to the PLL macro: register values
// in normal mode, the full pin set in test mode 0, or scan dividers
// with fixed safe controls in test mode 1

`timescale 1ns/100ps
`default_nettype none

module hsp_pll_cfg_mux
    import hsp_pkg::*;
(
    input  pll_mode_e i_pll_mode,
    input  pll_cfg_t  i_reg_cfg,
    input  pll_cfg_t  i_test_pll_cfg,
    input  pll_pms_t  i_sr_pll_pms,
    output pll_cfg_t  o_pll_cfg
);

    pll_cfg_t safe_cfg;

    // Test mode 1 set, only dividers and resetb come from outside
    always_comb begin
        safe_cfg.resetb       = i_test_pll_cfg.resetb;
        safe_cfg.bypass       = 1'b0;
        safe_cfg.lock_en      = 1'b1;
        safe_cfg.fout_mask    = 1'b0;
        safe_cfg.pms          = i_sr_pll_pms;
        safe_cfg.lock_con_in  = SAFE_LOCK_CON_IN;
        safe_cfg.lock_con_out = SAFE_LOCK_CON_OUT;
        safe_cfg.lock_con_dly = SAFE_LOCK_CON_DLY;
        safe_cfg.lock_con_rev = SAFE_LOCK_CON_REV;
        safe_cfg.icp          = SAFE_ICP;
    end

    always_comb begin
        case (i_pll_mode)
            MODE_TEST0: o_pll_cfg = i_test_pll_cfg;
            MODE_TEST1: o_pll_cfg = safe_cfg;
            // Reserved code falls back to normal
            default:    o_pll_cfg = i_reg_cfg;
        endcase
    end

endmodule

`default_nettype wire
